//--- hdl/core_pkg.sv
// Core state package with sequencer states, core modes, PSR fields and load/store ops
package core_pkg;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_JUMP,
		SEQ_IRQ_SET,
		SEQ_IRQ_RET,
		SEQ_IDT_SET
	} seq_state_t;

	// Substates, shared encoding for entry and return flows
	localparam int SUB_W = 2;
	localparam logic [SUB_W-1:0] SUB_SET_HANDLER = 2'd0;
	localparam logic [SUB_W-1:0] SUB_SET_USPR = 2'd1;
	localparam logic [SUB_W-1:0] SUB_SET_KSPR = 2'd2;
	localparam logic [SUB_W-1:0] SUB_SET_JUMP = 2'd3;
	localparam logic [SUB_W-1:0] SUB_RET_CHECK = 2'd0;
	localparam logic [SUB_W-1:0] SUB_RET_KSPR = 2'd1;
	localparam logic [SUB_W-1:0] SUB_RET_USPR = 2'd2;
	localparam logic [SUB_W-1:0] SUB_RET_JUMP = 2'd3;

	localparam logic [1:0] CORE_MODE_KERNEL = 2'b00;
	localparam logic [1:0] CORE_MODE_USER = 2'b10;
	localparam int PSR_IRQ_EN_BIT = 2;
	localparam int PSR_MODE_LSB = 5;

	// Sysreg write modes
	localparam logic [1:0] SRMODE_NONE = 2'd0;
	localparam logic [1:0] SRMODE_IRQ_SET = 2'd1;
	localparam logic [1:0] SRMODE_IRQ_CLR = 2'd2;

	typedef enum logic [1:0] {
		LDST_NONE,
		LDST_RD_HANDLER,
		LDST_WR_SPR,
		LDST_RD_SPR
	} ldst_op_t;

endpackage

//--- hdl/ldst_pkg.sv
// Memory layout package for the interrupt descriptor table and task state table
package ldst_pkg;

	localparam int WORD_W = 32;

	// IDT geometry
	localparam int IDT_ENTRIES = 64;
	localparam int IDT_IDX_W = $clog2(IDT_ENTRIES);
	localparam logic [WORD_W-1:0] IDT_ENTRY_BYTES = 32'd8;
	localparam logic [WORD_W-1:0] IDT_HANDLER_OFS = 32'd4;

	// Task state table, one 256 byte entry per task id
	localparam int TST_TASK_ID_W = 14;
	localparam int TST_STRIDE_SHIFT = 8;
	localparam logic [WORD_W-1:0] TST_USPR_OFS = 32'd0;
	localparam logic [WORD_W-1:0] TST_KSPR_OFS = 32'd4;

	typedef struct packed {
		logic [13:0] rsvd_hi;
		logic [1:0] level;
		logic [13:0] rsvd_lo;
		logic mask;
		logic valid;
	} idt_cfg_t;

	// Config entry at offset 0, handler address at offset 4
	typedef union packed {
		idt_cfg_t cfg;
		logic [WORD_W-1:0] handler;
	} idt_word_u;

endpackage

//--- hdl/sysreg_snapshot.sv
// System register snapshot, frozen while the sequencer is busy, with task slot addresses
`timescale 1ns/1ps

module sysreg_snapshot import core_pkg::*, ldst_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic idle,
	input logic [WORD_W-1:0] spr,
	input logic [WORD_W-1:0] tidr,
	input logic [WORD_W-1:0] tisr,
	input logic [WORD_W-1:0] psr,
	input logic [WORD_W-1:0] ppsr,
	input logic [WORD_W-1:0] ppcr,
	input logic [WORD_W-1:0] idtr,
	output logic [1:0] psr_mode,
	output logic [1:0] ppsr_mode,
	output logic [WORD_W-1:0] snap_spr,
	output logic [WORD_W-1:0] snap_ppcr,
	output logic [WORD_W-1:0] snap_idtr,
	output logic [WORD_W-1:0] uspr_addr,
	output logic [WORD_W-1:0] kspr_addr
);

	logic [WORD_W-1:0] task_base;

	// Entry of the current task in the task state table
	assign task_base = tisr + (WORD_W'(tidr[TST_TASK_ID_W-1:0]) << TST_STRIDE_SHIFT);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			psr_mode <= CORE_MODE_KERNEL;
			ppsr_mode <= CORE_MODE_KERNEL;
			snap_spr <= '0;
			snap_ppcr <= '0;
			snap_idtr <= '0;
			uspr_addr <= '0;
			kspr_addr <= '0;
		end else if (idle) begin
			psr_mode <= psr[PSR_MODE_LSB +: 2];
			ppsr_mode <= ppsr[PSR_MODE_LSB +: 2];
			snap_spr <= spr;
			snap_ppcr <= ppcr;
			snap_idtr <= idtr;
			uspr_addr <= task_base + TST_USPR_OFS;
			kspr_addr <= task_base + TST_KSPR_OFS;
		end
	end

endmodule

//--- hdl/exception_sequencer.sv
// Exception sequencer FSM for jump, interrupt entry, interrupt return and IDT set
`timescale 1ns/1ps

module exception_sequencer import core_pkg::*, ldst_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic exc_jump,
	input logic [WORD_W-1:0] exc_jump_addr,
	input logic exc_irq_req,
	input logic [6:0] exc_irq_num,
	input logic [WORD_W-1:0] exc_irq_fi0r,
	input logic exc_ib,
	input logic exc_idts,
	input logic irq_lock,
	input logic [WORD_W-1:0] psr,
	input logic [WORD_W-1:0] pcr,
	input logic [1:0] psr_mode,
	input logic [1:0] ppsr_mode,
	input logic [WORD_W-1:0] snap_spr,
	input logic [WORD_W-1:0] snap_ppcr,
	output ldst_op_t op,
	output logic [6:0] irq_num,
	output logic [WORD_W-1:0] wdata,
	input logic done,
	input logic [WORD_W-1:0] rdata,
	output logic idt_start,
	input logic idt_done,
	output logic idle,
	output logic pc_set,
	output logic [WORD_W-1:0] pc,
	output logic ppcr_set,
	output logic [WORD_W-1:0] ppcr_out,
	output logic fi0r_set,
	output logic [WORD_W-1:0] fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic spr_write,
	output logic [WORD_W-1:0] spr_out,
	output logic pipeline_flush,
	output logic pipeline_stop,
	output logic irq_ack,
	output logic ldst_use
);

	seq_state_t state_q;
	logic [SUB_W-1:0] sub_q;
	ldst_op_t op_q;
	logic [1:0] srmode_q;
	logic pc_set_q;
	logic ppcr_set_q;
	logic fi0r_set_q;
	logic spr_write_q;
	logic flush_q;
	logic ack_q;
	logic idt_start_q;
	logic [WORD_W-1:0] pc_q;
	logic [WORD_W-1:0] ppcr_q;
	logic [WORD_W-1:0] fi0r_q;
	logic [WORD_W-1:0] spr_out_q;
	logic [6:0] irq_num_q;
	logic irq_ok;

	assign irq_ok = exc_irq_req && !irq_lock && psr[PSR_IRQ_EN_BIT];
	assign idle = (state_q == SEQ_IDLE);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= SEQ_IDLE;
			sub_q <= '0;
			op_q <= LDST_NONE;
			srmode_q <= SRMODE_NONE;
			pc_set_q <= 1'b0;
			ppcr_set_q <= 1'b0;
			fi0r_set_q <= 1'b0;
			spr_write_q <= 1'b0;
			flush_q <= 1'b0;
			ack_q <= 1'b0;
			idt_start_q <= 1'b0;
		end else begin
			// Every strobe lasts one cycle
			op_q <= LDST_NONE;
			srmode_q <= SRMODE_NONE;
			pc_set_q <= 1'b0;
			ppcr_set_q <= 1'b0;
			fi0r_set_q <= 1'b0;
			spr_write_q <= 1'b0;
			flush_q <= 1'b0;
			ack_q <= 1'b0;
			idt_start_q <= 1'b0;
			case (state_q)
				SEQ_IDLE: begin
					sub_q <= '0;
					if (exc_jump) begin
						state_q <= SEQ_JUMP;
						flush_q <= 1'b1;
					end else if (irq_ok) begin
						state_q <= SEQ_IRQ_SET;
						flush_q <= 1'b1;
						ppcr_set_q <= 1'b1;
						srmode_q <= SRMODE_IRQ_SET;
						op_q <= LDST_RD_HANDLER;
					end else if (exc_idts) begin
						state_q <= SEQ_IDT_SET;
						flush_q <= 1'b1;
						idt_start_q <= 1'b1;
					end else if (exc_ib) begin
						state_q <= SEQ_IRQ_RET;
						flush_q <= 1'b1;
					end
				end
				SEQ_JUMP: begin
					pc_set_q <= 1'b1;
					state_q <= SEQ_IDLE;
				end
				SEQ_IRQ_SET: begin
					case (sub_q)
						SUB_SET_HANDLER: begin
							if (done) begin
								// Kernel code keeps its stack
								if (psr_mode == CORE_MODE_KERNEL) begin
									sub_q <= SUB_SET_JUMP;
								end else begin
									op_q <= LDST_WR_SPR;
									sub_q <= SUB_SET_USPR;
								end
							end
						end
						SUB_SET_USPR: begin
							if (done) begin
								op_q <= LDST_RD_SPR;
								sub_q <= SUB_SET_KSPR;
							end
						end
						SUB_SET_KSPR: begin
							if (done) begin
								spr_write_q <= 1'b1;
								sub_q <= SUB_SET_JUMP;
							end
						end
						SUB_SET_JUMP: begin
							pc_set_q <= 1'b1;
							ack_q <= 1'b1;
							fi0r_set_q <= 1'b1;
							state_q <= SEQ_IDLE;
						end
					endcase
				end
				SEQ_IRQ_RET: begin
					case (sub_q)
						SUB_RET_CHECK: begin
							if (ppsr_mode == CORE_MODE_USER) begin
								op_q <= LDST_WR_SPR;
								sub_q <= SUB_RET_KSPR;
							end else begin
								sub_q <= SUB_RET_JUMP;
							end
						end
						SUB_RET_KSPR: begin
							if (done) begin
								op_q <= LDST_RD_SPR;
								sub_q <= SUB_RET_USPR;
							end
						end
						SUB_RET_USPR: begin
							if (done) begin
								spr_write_q <= 1'b1;
								sub_q <= SUB_RET_JUMP;
							end
						end
						SUB_RET_JUMP: begin
							pc_set_q <= 1'b1;
							srmode_q <= SRMODE_IRQ_CLR;
							state_q <= SEQ_IDLE;
						end
					endcase
				end
				SEQ_IDT_SET: begin
					if (idt_done) begin
						pc_set_q <= 1'b1;
						state_q <= SEQ_IDLE;
					end
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// Event data is captured while idle and held through the flow
	always_ff @(posedge iCLOCK) begin
		if (idle) begin
			pc_q <= exc_jump_addr;
			ppcr_q <= pcr;
			fi0r_q <= exc_irq_fi0r;
			irq_num_q <= exc_irq_num;
		end else if (state_q == SEQ_IRQ_SET && sub_q == SUB_SET_HANDLER && done) begin
			pc_q <= rdata;
		end else if (state_q == SEQ_IRQ_RET && sub_q == SUB_RET_CHECK) begin
			pc_q <= snap_ppcr;
		end
		if (done) begin
			spr_out_q <= rdata;
		end
	end

	assign op = op_q;
	assign irq_num = irq_num_q;
	assign wdata = snap_spr;
	assign idt_start = idt_start_q;
	assign pc_set = pc_set_q;
	assign pc = pc_q;
	assign ppcr_set = ppcr_set_q;
	assign ppcr_out = ppcr_q;
	assign fi0r_set = fi0r_set_q;
	assign fi0r = fi0r_q;
	assign set_irq_mode = (srmode_q == SRMODE_IRQ_SET);
	assign clr_irq_mode = (srmode_q == SRMODE_IRQ_CLR);
	assign spr_write = spr_write_q;
	assign spr_out = spr_out_q;
	assign pipeline_flush = flush_q;
	assign irq_ack = ack_q;
	assign ldst_use = !idle;
	// Hold the pipeline as soon as an interrupt wins arbitration
	assign pipeline_stop = !idle || (!exc_jump && irq_ok);

endmodule

//--- hdl/ldst_port.sv
// Single-word load/store engine serving one sequencer step at a time
`timescale 1ns/1ps

module ldst_port import core_pkg::*, ldst_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input ldst_op_t op,
	input logic [6:0] irq_num,
	input logic [WORD_W-1:0] wdata,
	input logic [WORD_W-1:0] idtr,
	input logic [WORD_W-1:0] uspr_addr,
	input logic [WORD_W-1:0] kspr_addr,
	output logic done,
	output logic [WORD_W-1:0] rdata,
	output logic req,
	output logic rw,
	output logic [WORD_W-1:0] addr,
	output logic [WORD_W-1:0] ldst_wdata,
	input logic ldst_busy,
	input logic ldst_valid,
	input logic [WORD_W-1:0] ldst_rdata
);

	ldst_op_t op_q;
	logic pend_q;
	logic wait_q;
	logic done_q;
	logic chain_q;
	logic wr_user_q;
	logic take_op;
	logic [WORD_W-1:0] op_addr;
	logic [WORD_W-1:0] addr_q;
	logic [WORD_W-1:0] wdata_q;
	logic [WORD_W-1:0] rdata_q;
	idt_word_u ret_word;

	assign take_op = (op != LDST_NONE) && !pend_q && !wait_q;
	assign ret_word = ldst_rdata;

	// Entry chains its SPR write straight off the handler read,
	// so a write right after a handler read goes to the user slot
	always_comb begin
		case (op)
			LDST_RD_HANDLER:
				op_addr = idtr + WORD_W'(irq_num) * IDT_ENTRY_BYTES + IDT_HANDLER_OFS;
			LDST_WR_SPR: op_addr = chain_q ? uspr_addr : kspr_addr;
			LDST_RD_SPR: op_addr = wr_user_q ? kspr_addr : uspr_addr;
			default: op_addr = idtr;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			op_q <= LDST_NONE;
			pend_q <= 1'b0;
			wait_q <= 1'b0;
			done_q <= 1'b0;
			chain_q <= 1'b0;
			wr_user_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			chain_q <= done_q && (op_q == LDST_RD_HANDLER);
			if (take_op) begin
				op_q <= op;
				pend_q <= 1'b1;
				if (op == LDST_WR_SPR) begin
					wr_user_q <= chain_q;
				end
			end else begin
				if (req) begin
					pend_q <= 1'b0;
					wait_q <= 1'b1;
				end
				if (wait_q && ldst_valid) begin
					wait_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (take_op) begin
			addr_q <= op_addr;
			wdata_q <= wdata;
		end
		if (wait_q && ldst_valid) begin
			// The handler view spans the whole word and serves every read
			rdata_q <= ret_word.handler;
		end
	end

	assign req = pend_q && !ldst_busy;
	assign rw = (op_q == LDST_WR_SPR);
	assign addr = addr_q;
	assign ldst_wdata = wdata_q;
	assign done = done_q;
	assign rdata = rdata_q;

endmodule

//--- hdl/idt_loader.sv
// Pipelined IDT sweep loading all 64 entries into the interrupt configuration table
`timescale 1ns/1ps

module idt_loader import ldst_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic start,
	input logic [WORD_W-1:0] idtr,
	output logic req,
	output logic [WORD_W-1:0] addr,
	input logic ldst_busy,
	input logic ldst_valid,
	input logic [WORD_W-1:0] ldst_rdata,
	output logic done,
	output logic ict_write,
	output logic [IDT_IDX_W-1:0] ict_entry,
	output logic ict_mask,
	output logic ict_valid,
	output logic [1:0] ict_level
);

	logic active_q;
	logic write_q;
	logic done_q;
	// Issue count has one extra bit, set once every read is out
	logic [IDT_IDX_W:0] issue_q;
	logic [IDT_IDX_W-1:0] ret_q;
	logic [IDT_IDX_W-1:0] entry_q;
	idt_word_u word_q;

	assign req = active_q && !issue_q[IDT_IDX_W] && !ldst_busy;
	assign addr = idtr + WORD_W'(issue_q[IDT_IDX_W-1:0]) * IDT_ENTRY_BYTES;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			active_q <= 1'b0;
			write_q <= 1'b0;
			done_q <= 1'b0;
			issue_q <= '0;
			ret_q <= '0;
		end else begin
			write_q <= 1'b0;
			done_q <= 1'b0;
			if (start) begin
				active_q <= 1'b1;
				issue_q <= '0;
				ret_q <= '0;
			end else if (active_q) begin
				if (req) begin
					issue_q <= issue_q + 1'b1;
				end
				// Returns come back in order
				if (ldst_valid) begin
					ret_q <= ret_q + 1'b1;
					write_q <= 1'b1;
					if (ret_q == IDT_IDX_W'(IDT_ENTRIES - 1)) begin
						active_q <= 1'b0;
						done_q <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (active_q && ldst_valid) begin
			word_q <= ldst_rdata;
			entry_q <= ret_q;
		end
	end

	assign done = done_q;
	assign ict_write = write_q;
	assign ict_entry = entry_q;
	assign ict_mask = word_q.cfg.mask;
	assign ict_valid = word_q.cfg.valid;
	assign ict_level = word_q.cfg.level;

endmodule

//--- hdl/exception_manager.sv
// Exception manager top, joining the snapshot, sequencer and both memory engines
`timescale 1ns/1ps

module exception_manager import core_pkg::*, ldst_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	// Core events
	input logic exc_jump,
	input logic [WORD_W-1:0] exc_jump_addr,
	input logic exc_irq_req,
	input logic [6:0] exc_irq_num,
	input logic [WORD_W-1:0] exc_irq_fi0r,
	input logic exc_ib,
	input logic exc_idts,
	input logic irq_lock,
	// System registers
	input logic [WORD_W-1:0] spr,
	input logic [WORD_W-1:0] tidr,
	input logic [WORD_W-1:0] tisr,
	input logic [WORD_W-1:0] psr,
	input logic [WORD_W-1:0] ppsr,
	input logic [WORD_W-1:0] pcr,
	input logic [WORD_W-1:0] ppcr,
	input logic [WORD_W-1:0] idtr,
	// Core control
	output logic pc_set,
	output logic [WORD_W-1:0] pc,
	output logic ppcr_set,
	output logic [WORD_W-1:0] ppcr_out,
	output logic fi0r_set,
	output logic [WORD_W-1:0] fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic spr_write,
	output logic [WORD_W-1:0] spr_out,
	output logic pipeline_flush,
	output logic pipeline_stop,
	output logic irq_ack,
	// Interrupt configuration table
	output logic ict_write,
	output logic [IDT_IDX_W-1:0] ict_entry,
	output logic ict_mask,
	output logic ict_valid,
	output logic [1:0] ict_level,
	// Load/store port
	output logic ldst_use,
	output logic ldst_req,
	output logic ldst_rw,
	output logic [WORD_W-1:0] ldst_addr,
	output logic [WORD_W-1:0] ldst_wdata,
	input logic ldst_busy,
	input logic ldst_valid,
	input logic [WORD_W-1:0] ldst_rdata
);

	logic idle;
	logic [1:0] psr_mode;
	logic [1:0] ppsr_mode;
	logic [WORD_W-1:0] snap_spr;
	logic [WORD_W-1:0] snap_ppcr;
	logic [WORD_W-1:0] snap_idtr;
	logic [WORD_W-1:0] uspr_addr;
	logic [WORD_W-1:0] kspr_addr;
	ldst_op_t op;
	logic [6:0] irq_num;
	logic [WORD_W-1:0] seq_wdata;
	logic lp_done;
	logic [WORD_W-1:0] lp_rdata;
	logic lp_req;
	logic lp_rw;
	logic [WORD_W-1:0] lp_addr;
	logic idt_start;
	logic idt_done;
	logic il_req;
	logic [WORD_W-1:0] il_addr;

	sysreg_snapshot u_snapshot (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .idle(idle),
		.spr(spr), .tidr(tidr), .tisr(tisr), .psr(psr), .ppsr(ppsr),
		.ppcr(ppcr), .idtr(idtr),
		.psr_mode(psr_mode), .ppsr_mode(ppsr_mode),
		.snap_spr(snap_spr), .snap_ppcr(snap_ppcr), .snap_idtr(snap_idtr),
		.uspr_addr(uspr_addr), .kspr_addr(kspr_addr)
	);

	exception_sequencer u_sequencer (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.exc_jump(exc_jump), .exc_jump_addr(exc_jump_addr),
		.exc_irq_req(exc_irq_req), .exc_irq_num(exc_irq_num),
		.exc_irq_fi0r(exc_irq_fi0r), .exc_ib(exc_ib), .exc_idts(exc_idts),
		.irq_lock(irq_lock), .psr(psr), .pcr(pcr),
		.psr_mode(psr_mode), .ppsr_mode(ppsr_mode),
		.snap_spr(snap_spr), .snap_ppcr(snap_ppcr),
		.op(op), .irq_num(irq_num), .wdata(seq_wdata),
		.done(lp_done), .rdata(lp_rdata),
		.idt_start(idt_start), .idt_done(idt_done), .idle(idle),
		.pc_set(pc_set), .pc(pc), .ppcr_set(ppcr_set), .ppcr_out(ppcr_out),
		.fi0r_set(fi0r_set), .fi0r(fi0r),
		.set_irq_mode(set_irq_mode), .clr_irq_mode(clr_irq_mode),
		.spr_write(spr_write), .spr_out(spr_out),
		.pipeline_flush(pipeline_flush), .pipeline_stop(pipeline_stop),
		.irq_ack(irq_ack), .ldst_use(ldst_use)
	);

	ldst_port u_ldst_port (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.op(op), .irq_num(irq_num), .wdata(seq_wdata),
		.idtr(snap_idtr), .uspr_addr(uspr_addr), .kspr_addr(kspr_addr),
		.done(lp_done), .rdata(lp_rdata),
		.req(lp_req), .rw(lp_rw), .addr(lp_addr), .ldst_wdata(ldst_wdata),
		.ldst_busy(ldst_busy), .ldst_valid(ldst_valid), .ldst_rdata(ldst_rdata)
	);

	idt_loader u_idt_loader (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.start(idt_start), .idtr(snap_idtr),
		.req(il_req), .addr(il_addr),
		.ldst_busy(ldst_busy), .ldst_valid(ldst_valid), .ldst_rdata(ldst_rdata),
		.done(idt_done), .ict_write(ict_write), .ict_entry(ict_entry),
		.ict_mask(ict_mask), .ict_valid(ict_valid), .ict_level(ict_level)
	);

	// The two engines never run together
	assign ldst_req = lp_req | il_req;
	assign ldst_addr = il_req ? il_addr : lp_addr;
	assign ldst_rw = lp_req & lp_rw;

endmodule

//--- tests/exception_manager_assert.sv
// Concurrent protocol and timing checks for the exception manager, bound to the top
`timescale 1ns/1ps

module exception_manager_assert (
	input logic iCLOCK,
	input logic inRESET,
	input logic exc_jump,
	input logic [31:0] exc_jump_addr,
	input logic ldst_use,
	input logic pipeline_flush,
	input logic pc_set,
	input logic [31:0] pc,
	input logic irq_ack,
	input logic fi0r_set,
	input logic clr_irq_mode,
	input logic ppcr_set,
	input logic set_irq_mode,
	input logic spr_write,
	input logic ldst_req,
	input logic ldst_busy
);

	int fail_count = 0;

	// Every pulse output stays low under reset
	a_reset_quiet: assert property (@(posedge iCLOCK)
		!inRESET |-> !(pc_set || irq_ack || fi0r_set || spr_write || ldst_req || pipeline_flush))
		else begin
			fail_count++;
			$error("pulse output high during reset");
		end

	// Jump from idle: flush next cycle, then pc_set with the sampled address
	a_jump_timing: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(exc_jump && !ldst_use) |=> pipeline_flush ##1 (pc_set && pc == $past(exc_jump_addr, 2)))
		else begin
			fail_count++;
			$error("jump did not give flush then pc_set with the jump address");
		end

	a_no_req_when_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_req |-> !ldst_busy)
		else begin
			fail_count++;
			$error("ldst_req high while ldst_busy high");
		end

	// Memory traffic only while a flow owns the port
	a_req_in_flow: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_req |-> ldst_use)
		else begin
			fail_count++;
			$error("ldst_req high while ldst_use low");
		end

	a_ack_with_pc: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		irq_ack |-> (pc_set && fi0r_set))
		else begin
			fail_count++;
			$error("irq_ack without pc_set and fi0r_set");
		end

	a_clr_with_pc: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		clr_irq_mode |-> pc_set)
		else begin
			fail_count++;
			$error("clr_irq_mode without pc_set");
		end

	a_ppcr_with_mode: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ppcr_set |-> set_irq_mode)
		else begin
			fail_count++;
			$error("ppcr_set without set_irq_mode");
		end

endmodule

bind exception_manager exception_manager_assert u_assert (
	.iCLOCK(iCLOCK), .inRESET(inRESET),
	.exc_jump(exc_jump), .exc_jump_addr(exc_jump_addr), .ldst_use(ldst_use),
	.pipeline_flush(pipeline_flush), .pc_set(pc_set), .pc(pc),
	.irq_ack(irq_ack), .fi0r_set(fi0r_set), .clr_irq_mode(clr_irq_mode),
	.ppcr_set(ppcr_set), .set_irq_mode(set_irq_mode), .spr_write(spr_write),
	.ldst_req(ldst_req), .ldst_busy(ldst_busy)
);

//--- tests/tb_exception_manager.sv
// Testbench for the exception manager with a load/store memory model and event stimulus
`timescale 1ns/1ps

module tb_exception_manager;

	localparam int CLK_NS = 20;
	localparam int IDT_SWEEP_NS = 64 * 8 * CLK_NS;
	localparam int OTHER_NS = 2000;
	localparam int TIMEOUT_NS = IDT_SWEEP_NS + 5 * OTHER_NS + 8 * CLK_NS;
	localparam logic [31:0] IDTR = 32'h0000_1000;
	localparam logic [31:0] TISR = 32'h0000_4000;
	localparam logic [31:0] TIDR = 32'd3;
	localparam logic [31:0] USPR_ADDR = TISR + (TIDR << 8);
	localparam logic [31:0] KSPR_ADDR = USPR_ADDR + 32'd4;
	// Enable bit 2, mode field at bits 6:5 with user mode 2'b10
	localparam logic [31:0] PSR_KERNEL_EN = 32'h0000_0004;
	localparam logic [31:0] PSR_USER_EN = 32'h0000_0044;
	localparam logic [31:0] PSR_USER = 32'h0000_0040;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic exc_jump, exc_irq_req, exc_ib, exc_idts, irq_lock;
	logic [31:0] exc_jump_addr, exc_irq_fi0r;
	logic [6:0] exc_irq_num;
	logic [31:0] spr, tidr, tisr, psr, ppsr, pcr, ppcr, idtr;
	logic pc_set, ppcr_set, fi0r_set, set_irq_mode, clr_irq_mode, spr_write;
	logic pipeline_flush, pipeline_stop, irq_ack;
	logic [31:0] pc, ppcr_out, fi0r, spr_out;
	logic ict_write, ict_mask, ict_valid;
	logic [5:0] ict_entry;
	logic [1:0] ict_level;
	logic ldst_use, ldst_req, ldst_rw, ldst_busy, ldst_valid;
	logic [31:0] ldst_addr, ldst_wdata, ldst_rdata;

	integer seed;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base;
	int cyc = 0;
	int last_due = 0;
	logic [31:0] mem [logic [31:0]];
	logic [31:0] rd_addr_q [$];
	int rd_due_q [$];
	logic [31:0] acc_addr [$];
	logic acc_rw [$];
	logic [31:0] acc_data [$];
	logic [5:0] ict_entries [$];
	logic [3:0] ict_fields [$];
	logic pc_seen, spr_seen, spr_before_pc, ppcr_seen;
	logic ack_at_pc, fi0r_set_at_pc, clr_at_pc;
	logic [31:0] pc_val, spr_val, ppcr_val, fi0r_val;
	int ack_count;
	int stop_count;

	exception_manager u_dut (.*);

	always #(CLK_NS / 2) iCLOCK = ~iCLOCK;

	// Unwritten words follow a pattern of the whole address
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return {a[15:0], a[31:16]} ^ 32'h3c5a_9e71;
	endfunction

	// Memory side, accepted requests are taken where signals are stable
	always @(negedge iCLOCK) begin
		int d;
		int due;
		if (inRESET && ldst_req && !ldst_busy) begin
			d = 1 + int'({$random(seed)} % 3);
			due = (cyc + d > last_due) ? cyc + d : last_due + 1;
			last_due = due;
			acc_addr.push_back(ldst_addr);
			acc_rw.push_back(ldst_rw);
			acc_data.push_back(ldst_wdata);
			if (ldst_rw) begin
				mem[ldst_addr] = ldst_wdata;
			end
			rd_addr_q.push_back(ldst_addr);
			rd_due_q.push_back(due);
		end
	end

	always @(posedge iCLOCK or negedge inRESET) begin
		logic [31:0] a;
		if (!inRESET) begin
			ldst_busy <= 1'b0;
			ldst_valid <= 1'b0;
			ldst_rdata <= '0;
		end else begin
			cyc = cyc + 1;
			ldst_busy <= ({$random(seed)} % 4) == 0;
			ldst_valid <= 1'b0;
			if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
				a = rd_addr_q.pop_front();
				void'(rd_due_q.pop_front());
				ldst_valid <= 1'b1;
				ldst_rdata <= mem_word(a);
			end
		end
	end

	// Core side monitor
	always @(negedge iCLOCK) begin
		if (spr_write) begin
			spr_seen = 1'b1;
			spr_val = spr_out;
			spr_before_pc = !pc_seen;
		end
		if (ppcr_set) begin
			ppcr_seen = 1'b1;
			ppcr_val = ppcr_out;
		end
		if (ict_write) begin
			ict_entries.push_back(ict_entry);
			ict_fields.push_back({ict_mask, ict_valid, ict_level});
		end
		if (irq_ack) begin
			ack_count++;
		end
		if (pipeline_stop) begin
			stop_count++;
		end
		if (pc_set) begin
			pc_seen = 1'b1;
			pc_val = pc;
			ack_at_pc = irq_ack;
			fi0r_set_at_pc = fi0r_set;
			fi0r_val = fi0r;
			clr_at_pc = clr_irq_mode;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, a test did not complete", TIMEOUT_NS);
		$display("Finished with errors");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("ERROR at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic clear_monitor();
		pc_seen = 1'b0;
		spr_seen = 1'b0;
		spr_before_pc = 1'b0;
		ppcr_seen = 1'b0;
		ack_count = 0;
		stop_count = 0;
		acc_addr.delete();
		acc_rw.delete();
		acc_data.delete();
		ict_entries.delete();
		ict_fields.delete();
		test_err_base = errors;
	endtask

	task automatic wait_pc(input int max_cycles);
		int n;
		n = 0;
		while (!pc_seen && n < max_cycles) begin
			@(posedge iCLOCK);
			n++;
		end
		check_true(pc_seen, "pc_set never arrived");
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err_base) begin
			tests_failed++;
		end
		$display("test %0d %s: %s", tests_run, name, (errors == test_err_base) ? "ok" : "FAILED");
	endtask

	initial begin
		seed = 32'he7e5da02;
		inRESET = 1'b0;
		{exc_jump, exc_irq_req, exc_ib, exc_idts, irq_lock} = '0;
		exc_jump_addr = '0;
		exc_irq_fi0r = '0;
		exc_irq_num = '0;
		spr = 32'h5555_0001;
		tidr = TIDR;
		tisr = TISR;
		psr = PSR_KERNEL_EN;
		ppsr = '0;
		pcr = 32'h0000_2220;
		ppcr = 32'h0000_3330;
		idtr = IDTR;
		repeat (4) @(posedge iCLOCK);
		inRESET <= 1'b1;
		repeat (2) @(posedge iCLOCK);

		// Reset state and jump
		clear_monitor();
		check_true(!(pc_set || irq_ack || spr_write || ldst_req || ict_write),
			"pulse output high after reset");
		exc_jump <= 1'b1;
		exc_jump_addr <= 32'h0000_8a40;
		@(posedge iCLOCK);
		exc_jump <= 1'b0;
		wait_pc(8);
		check_value("pc", pc_val, 32'h0000_8a40);
		end_test("reset and jump");
		repeat (3) @(posedge iCLOCK);

		// Kernel-mode interrupt
		clear_monitor();
		exc_irq_req <= 1'b1;
		exc_irq_num <= 7'd5;
		exc_irq_fi0r <= 32'hf10f_0005;
		// Pending interrupt already holds the pipeline while still idle
		@(negedge iCLOCK);
		check_true(pipeline_stop && !ldst_use, "pipeline_stop low or ldst_use high while idle");
		@(posedge iCLOCK);
		exc_irq_req <= 1'b0;
		@(negedge iCLOCK);
		check_true(pipeline_stop && ldst_use, "pipeline_stop or ldst_use low during entry");
		wait_pc(100);
		check_value("pc", pc_val, mem_word(IDTR + 32'd8 * 32'd5 + 32'd4));
		check_true(ppcr_seen, "ppcr_set never pulsed");
		check_value("ppcr_out", ppcr_val, pcr);
		check_true(ack_at_pc && fi0r_set_at_pc, "irq_ack and fi0r_set not with pc_set");
		check_value("fi0r", fi0r_val, 32'hf10f_0005);
		foreach (acc_rw[i]) check_true(!acc_rw[i], "memory write during kernel interrupt");
		end_test("kernel-mode interrupt");
		repeat (3) @(posedge iCLOCK);

		// User-mode interrupt
		clear_monitor();
		psr <= PSR_USER_EN;
		repeat (2) @(posedge iCLOCK);
		exc_irq_req <= 1'b1;
		exc_irq_num <= 7'd9;
		@(posedge iCLOCK);
		exc_irq_req <= 1'b0;
		wait_pc(100);
		check_value("request count", acc_addr.size(), 32'd3);
		if (acc_addr.size() == 3) begin
			check_value("pc", pc_val, mem_word(IDTR + 32'd8 * 32'd9 + 32'd4));
			check_value("write addr", acc_addr[1], USPR_ADDR);
			check_value("write rw", 32'(acc_rw[1]), 32'd1);
			check_value("write data", acc_data[1], 32'h5555_0001);
			check_value("read addr", acc_addr[2], KSPR_ADDR);
			check_value("read rw", 32'(acc_rw[2]), 32'd0);
		end
		check_true(spr_seen && spr_before_pc, "spr_write missing or not before pc_set");
		check_value("spr_out", spr_val, mem_word(KSPR_ADDR));
		end_test("user-mode interrupt");
		repeat (3) @(posedge iCLOCK);

		// Interrupt return to user mode
		clear_monitor();
		psr <= PSR_KERNEL_EN;
		ppsr <= PSR_USER;
		spr <= 32'h7777_0002;
		repeat (2) @(posedge iCLOCK);
		exc_ib <= 1'b1;
		@(posedge iCLOCK);
		exc_ib <= 1'b0;
		wait_pc(100);
		check_value("request count", acc_addr.size(), 32'd2);
		if (acc_addr.size() == 2) begin
			check_value("write addr", acc_addr[0], KSPR_ADDR);
			check_value("write rw", 32'(acc_rw[0]), 32'd1);
			check_value("write data", acc_data[0], 32'h7777_0002);
			check_value("read addr", acc_addr[1], USPR_ADDR);
		end
		check_true(spr_seen && spr_before_pc, "spr_write missing or not before pc_set");
		check_value("spr_out", spr_val, mem_word(USPR_ADDR));
		check_value("pc", pc_val, ppcr);
		check_true(clr_at_pc, "clr_irq_mode not with pc_set");
		end_test("interrupt return to user");
		repeat (3) @(posedge iCLOCK);

		// IDT sweep with random busy
		clear_monitor();
		exc_idts <= 1'b1;
		@(posedge iCLOCK);
		exc_idts <= 1'b0;
		wait_pc(64 * 8);
		check_value("ict_write count", ict_entries.size(), 32'd64);
		foreach (ict_entries[i]) begin
			logic [31:0] w;
			w = mem_word(IDTR + 32'd8 * i);
			check_value("ict_entry", 32'(ict_entries[i]), i);
			check_value("ict fields", 32'(ict_fields[i]), 32'({w[1], w[0], w[17:16]}));
		end
		end_test("IDT set under busy");
		repeat (3) @(posedge iCLOCK);

		// Masked interrupts
		clear_monitor();
		psr <= 32'h0000_0000;
		exc_irq_req <= 1'b1;
		repeat (10) @(posedge iCLOCK);
		irq_lock <= 1'b1;
		psr <= PSR_KERNEL_EN;
		repeat (10) @(posedge iCLOCK);
		exc_irq_req <= 1'b0;
		irq_lock <= 1'b0;
		repeat (2) @(posedge iCLOCK);
		check_value("irq_ack count", ack_count, 32'd0);
		check_value("request count", acc_addr.size(), 32'd0);
		check_value("pipeline_stop cycles", stop_count, 32'd0);
		check_true(!pc_seen, "pc_set on a masked interrupt");
		end_test("masking");

		$display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
			tests_run, tests_failed, errors, u_dut.u_assert.fail_count);
		if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- compile.f
hdl/core_pkg.sv
hdl/ldst_pkg.sv
hdl/sysreg_snapshot.sv
hdl/exception_sequencer.sv
hdl/ldst_port.sv
hdl/idt_loader.sv
hdl/exception_manager.sv
tests/exception_manager_assert.sv
tests/tb_exception_manager.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the exception manager testbench with Verilator and runs it

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f \
	--top-module tb_exception_manager -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Finished with no errors$" &&
echo "simulation passed" ||
{
	echo "simulation failed"
	exit 1
}
